// ==== verilog.f ====
verilog/ls_isa_pkg.sv
verilog/ls_bus_pkg.sv
verilog/load_store_unit.sv
verilog/reg_file.sv
verilog/data_ram.sv
verilog/periph_bridge_ctrl.sv
verilog/wait_timer.sv
verilog/ls_subsystem_top.sv
tb/ls_clock_gen.sv
tb/ls_properties.sv
tb/ls_checker.sv
tb/ls_tb.sv

// ==== tb/ls_tb.sv ====
// *********************************************************************
// Random load/store stream from a fixed LFSR seed against a cycle model
// *********************************************************************

`timescale 1ns/1ps

module ls_tb;

  import ls_isa_pkg::*;
  import ls_bus_pkg::*;

  localparam int CLK_PERIOD = 8;
  localparam int RESET_CYCLES = 16;
  localparam logic [31:0] SEED = 32'h94a8d02a;
  // Sum of the operation counts of all tests below
  localparam int TOTAL_OPS = 190;
  localparam int LIMIT_CYCLES = TOTAL_OPS * (PERIPH_WAIT + 6) + RESET_CYCLES;

  logic        CLK;
  logic        RST;
  logic        op_vld;
  ls_op_t      op;
  logic        busy;
  rf_wr_t      ptr_wb;
  rf_wr_t      load_wb;
  rf_wr_t      periph_wb;
  logic [31:0] next_addr;
  int          err_count;
  logic [31:0] lfsr;
  int          n_pass;
  int          n_fail;

  ls_clock_gen ls_clock_gen_inst (.CLK(CLK), .RST(RST));

  ls_subsystem_top ls_subsystem_top_inst (
    .CLK       (CLK),
    .RST       (RST),
    .op_vld    (op_vld),
    .op        (op),
    .busy      (busy),
    .ptr_wb    (ptr_wb),
    .load_wb   (load_wb),
    .periph_wb (periph_wb)
  );

  ls_checker ls_checker_inst (
    .CLK       (CLK),
    .RST       (RST),
    .op_vld    (op_vld),
    .op        (op),
    .busy      (busy),
    .ptr_wb    (ptr_wb),
    .load_wb   (load_wb),
    .periph_wb (periph_wb),
    .next_addr (next_addr),
    .err_count (err_count)
  );

  bind load_store_unit ls_properties lsu_props_inst (
    .CLK(CLK), .RST(RST), .ram_cs(ram_req.cs), .periph_cs(periph_req.cs),
    .busy(1'b0), .wb_vld(1'b0)
  );

  bind periph_bridge_ctrl ls_properties bridge_props_inst (
    .CLK(CLK), .RST(RST), .ram_cs(1'b0), .periph_cs(req.cs),
    .busy(busy), .wb_vld(periph_wb.vld)
  );

  // Galois form of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'h80200003) : (s >> 1);
  endfunction

  // One LFSR step per bit taken, first bit ends up most significant
  task automatic draw_bits(input int n, output logic [31:0] v);
    v = '0;
    repeat (n)
    begin
      v = {v[30:0], lfsr[0]};
      lfsr = lfsr_step(lfsr);
    end
  endtask

  // Model mismatches plus assertion failures from both bound instances
  function automatic int total_errors();
    return err_count
         + int'(ls_subsystem_top_inst.load_store_unit_inst.lsu_props_inst.fail_count)
         + int'(ls_subsystem_top_inst.periph_bridge_ctrl_inst.bridge_props_inst.fail_count);
  endfunction

  // A mode of -1 leaves a field random, want_periph picks the address space
  task automatic run_test(input string name, input int n_ops, input int upd_mode,
                          input int size_mode, input logic want_periph,
                          input logic always_issue);
    int          issued;
    int          start_errs;
    int          tries;
    int          errs;
    logic [31:0] bits;
    logic        take;
    logic        ok;
    issued = 0;
    start_errs = total_errors();
    while (issued < n_ops)
    begin
      @(negedge CLK);
      op_vld = 1'b0;
      take = always_issue;
      if (!take)
      begin
        draw_bits(1, bits);
        take = bits[0];
      end
      ok = 1'b0;
      tries = 0;
      // Redraw until the model puts the address in the wanted space
      while (take && !ok && (tries < 4))
      begin
        draw_bits(15, bits);
        op = bits[14:0];
        if (upd_mode >= 0)
          op.upd = upd_mode[0];
        if (size_mode >= 0)
          op.size = ls_size_e'(size_mode[1:0]);
        #0.1;
        ok = (next_addr[31] == want_periph);
        tries++;
      end
      if (ok)
      begin
        op_vld = 1'b1;
        issued++;
        if (want_periph)
        begin
          @(negedge CLK);
          op_vld = 1'b0;
          @(negedge CLK);
          while (busy) @(negedge CLK);
        end
      end
    end
    @(negedge CLK);
    op_vld = 1'b0;
    // Let every load and peripheral return reach the checker
    repeat (PERIPH_WAIT + 6) @(negedge CLK);
    errs = total_errors() - start_errs;
    $display("test %-12s %3d ops, %0d mismatches, %s", name, n_ops, errs,
             (errs == 0) ? "pass" : "fail");
    if (errs == 0)
      n_pass++;
    else
      n_fail++;
  endtask

  initial
  begin
    op_vld = 1'b0;
    op = '0;
    lfsr = SEED;
    n_pass = 0;
    n_fail = 0;
    @(negedge RST);
    run_test("reset_idle", 0, -1, -1, 1'b0, 1'b0);
    // Peripheral space is reachable from all-zero registers by pre-decrement
    run_test("periph", 20, -1, -1, 1'b1, 1'b0);
    run_test("ptr_update", 40, 1, -1, 1'b0, 1'b0);
    run_test("store_load", 40, 0, -1, 1'b0, 1'b0);
    run_test("back_to_back", 60, -1, -1, 1'b0, 1'b1);
    run_test("swap", 30, -1, 3, 1'b0, 1'b0);
    $display("tests passed %0d, failed %0d", n_pass, n_fail);
    if (n_fail == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

  initial
  begin
    #(LIMIT_CYCLES * CLK_PERIOD);
    $display("timeout: the run did not finish within %0d cycles", LIMIT_CYCLES);
    $display("*** FAILED ***");
    $finish;
  end

endmodule

// ==== tb/ls_checker.sv ====
// *********************************************************************
// Cycle model of registers, RAM and peripheral bank behind the DUT
// Outputs are compared at falling edges, the model steps at rising ones
// *********************************************************************

`timescale 1ns/1ps

module ls_checker (
  input  logic               CLK,
  input  logic               RST,
  input  logic               op_vld,
  input  ls_isa_pkg::ls_op_t op,
  input  logic               busy,
  input  ls_bus_pkg::rf_wr_t ptr_wb,
  input  ls_bus_pkg::rf_wr_t load_wb,
  input  ls_bus_pkg::rf_wr_t periph_wb,
  output logic [31:0]        next_addr,
  output int                 err_count
);

  import ls_isa_pkg::*;
  import ls_bus_pkg::*;

  // Ring of predicted outputs, deep enough for the peripheral latency
  localparam int SLOTS = 16;

  logic [31:0] m_regs [8];
  logic [31:0] m_ram [RAM_WORDS];
  logic [31:0] m_bank [PERIPH_WORDS];
  rf_wr_t      want_ptr [SLOTS];
  rf_wr_t      want_load [SLOTS];
  rf_wr_t      want_periph [SLOTS];
  logic        want_busy [SLOTS];
  int          cyc;
  int          errs = 0;
  logic [31:0] probe_ptr;

  assign err_count = errs;

  // Offset in bytes, signed only for pointer updates
  function automatic logic signed [31:0] byte_offset(ls_op_t o);
    int scale;
    int off;
    scale = (o.size == SIZE_BYTE) ? 1 : ((o.size == SIZE_HALF) ? 2 : 4);
    if (o.upd)
      off = $signed(o.imm);
    else
      off = o.imm;
    return off * scale;
  endfunction

  // Post-increment uses the old pointer, everything else the sum
  function automatic logic [31:0] access_addr(ls_op_t o, logic [31:0] ptr);
    logic signed [31:0] off;
    off = byte_offset(o);
    if (o.upd && (off >= 0))
      return ptr;
    return ptr + off;
  endfunction

  // Address the next operation on the bus will use, for the issuer
  assign probe_ptr = m_regs[op.ptr_sel];
  assign next_addr = access_addr(op, probe_ptr);

  function automatic logic [31:0] merge_store(logic [31:0] old, logic [31:0] sdata,
                                             ls_size_e size, logic [1:0] lane);
    logic [31:0] keep;
    logic [31:0] placed;
    case (size)
      SIZE_BYTE:
      begin
        keep   = 32'hff << (8 * lane);
        placed = {24'd0, sdata[7:0]} << (8 * lane);
      end
      SIZE_HALF:
      begin
        keep   = 32'hffff << (16 * lane[1]);
        placed = {16'd0, sdata[15:0]} << (16 * lane[1]);
      end
      default:
      begin
        keep   = 32'hffffffff;
        placed = sdata;
      end
    endcase
    return (old & ~keep) | placed;
  endfunction

  // Loads are zero-extended from the addressed lane
  function automatic logic [31:0] extract_load(logic [31:0] word, ls_size_e size,
                                              logic [1:0] lane);
    case (size)
      SIZE_BYTE: return (word >> (8 * lane)) & 32'hff;
      SIZE_HALF: return (word >> (16 * lane[1])) & 32'hffff;
      default:   return word;
    endcase
  endfunction

  always @(posedge CLK)
  begin : model_step
    logic [31:0] ptr;
    logic [31:0] sdata;
    logic [31:0] addr;
    logic [31:0] old;
    int prev;
    if (RST)
    begin
      cyc = 0;
      for (int i = 0; i < 8; i++) m_regs[i] = '0;
      for (int i = 0; i < RAM_WORDS; i++) m_ram[i] = '0;
      for (int i = 0; i < PERIPH_WORDS; i++) m_bank[i] = '0;
      for (int i = 0; i < SLOTS; i++)
      begin
        want_ptr[i] = '0;
        want_load[i] = '0;
        want_periph[i] = '0;
        want_busy[i] = 1'b0;
      end
    end
    else
    begin
      // The DUT reads its registers before this edge's writes land
      ptr   = m_regs[op.ptr_sel];
      sdata = m_regs[op.data_sel];
      prev  = cyc % SLOTS;
      cyc   = cyc + 1;
      // Later writes override earlier ones, so periph_wb ends up on top
      if (want_ptr[prev].vld) m_regs[want_ptr[prev].sel] = want_ptr[prev].data;
      if (want_load[prev].vld) m_regs[want_load[prev].sel] = want_load[prev].data;
      if (want_periph[prev].vld) m_regs[want_periph[prev].sel] = want_periph[prev].data;
      want_ptr[prev] = '0;
      want_load[prev] = '0;
      want_periph[prev] = '0;
      want_busy[prev] = 1'b0;
      if (op_vld)
      begin
        addr = access_addr(op, ptr);
        if (op.upd)
          want_ptr[cyc % SLOTS] = '{vld: 1'b1, sel: op.ptr_sel, data: ptr + byte_offset(op)};
        if (!addr[31])
        begin
          // The RAM acts in order, so doing the access now gives the same word
          old = m_ram[addr[7:2]];
          if (op.wr)
            m_ram[addr[7:2]] = merge_store(old, sdata, op.size, addr[1:0]);
          if (!op.wr || (op.size == SIZE_SWAP))
            want_load[(cyc + 2) % SLOTS] = '{vld: 1'b1, sel: op.data_sel,
                                            data: extract_load(old, op.size, addr[1:0])};
        end
        else
        begin
          old = m_bank[addr[5:2]];
          if (op.wr)
            m_bank[addr[5:2]] = merge_store(old, sdata, op.size, addr[1:0]);
          // Bridge is busy from one cycle after the request for the whole wait
          for (int k = 1; k <= PERIPH_WAIT + 2; k++) want_busy[(cyc + k) % SLOTS] = 1'b1;
          if (!op.wr || (op.size == SIZE_SWAP))
            want_periph[(cyc + PERIPH_WAIT + 2) % SLOTS] = '{vld: 1'b1, sel: op.data_sel,
                                                             data: old};
        end
      end
    end
  end

  task automatic check_wb(input string name, input rf_wr_t got, input rf_wr_t want);
    if (got.vld !== want.vld)
    begin
      if (want.vld)
        $display("%s strobe missing in cycle %0d, r%0d was due", name, cyc, want.sel);
      else
        $display("unexpected %s strobe in cycle %0d", name, cyc);
      errs++;
    end
    else if (want.vld && ((got.sel !== want.sel) || (got.data !== want.data)))
    begin
      $display("ERROR %s: sel %h data %h, expected sel %h data %h", name,
               got.sel, got.data, want.sel, want.data);
      errs++;
    end
  endtask

  // Outputs settle after the rising edge and are compared mid-cycle
  always @(negedge CLK)
  begin : compare
    int s;
    if (!RST)
    begin
      s = cyc % SLOTS;
      check_wb("ptr_wb", ptr_wb, want_ptr[s]);
      check_wb("load_wb", load_wb, want_load[s]);
      check_wb("periph_wb", periph_wb, want_periph[s]);
      if (busy !== want_busy[s])
      begin
        $display("ERROR busy: %h, expected %h", busy, want_busy[s]);
        errs++;
      end
    end
  end

endmodule

// ==== tb/ls_properties.sv ====
// *********************************************************************
// Protocol assertions, bound once into the unit and once into the bridge
// Inputs unused at one bind point are tied low there
// *********************************************************************

`timescale 1ns/1ps

module ls_properties (
  input logic CLK,
  input logic RST,
  input logic ram_cs,
  input logic periph_cs,
  input logic busy,
  input logic wb_vld
);

  // Failures seen so far, read by the testbench for its verdict
  int unsigned fail_count = 0;

  // One address picks one space, so the two chip selects never overlap
  one_space_a: assert property (@(posedge CLK) disable iff (RST) !(ram_cs && periph_cs))
    else
    begin
      $error("RAM and peripheral chip selects are high in the same cycle");
      fail_count++;
    end

  // The timer only starts from idle, a request during an access would be lost
  start_idle_a: assert property (@(posedge CLK) disable iff (RST) !(periph_cs && busy))
    else
    begin
      $error("peripheral request arrived while the bridge is busy");
      fail_count++;
    end

  // Read or swap data comes back for exactly one cycle
  wb_pulse_a: assert property (@(posedge CLK) disable iff (RST) wb_vld |=> !wb_vld)
    else
    begin
      $error("periph_wb strobe held longer than one cycle");
      fail_count++;
    end

endmodule

// ==== tb/ls_clock_gen.sv ====
// *********************************************************************
// Free-running 8 ns clock, reset released on a falling edge
// *********************************************************************

`timescale 1ns/1ps

module ls_clock_gen (
  output logic CLK,
  output logic RST
);

  localparam int HALF_PERIOD = 4;
  localparam int RESET_CYCLES = 16;

  initial
  begin
    CLK = 1'b0;
    forever #(HALF_PERIOD) CLK = ~CLK;
  end

  // Reset spans 16 rising edges and drops away from any rising edge
  initial
  begin
    RST = 1'b1;
    repeat (RESET_CYCLES) @(posedge CLK);
    @(negedge CLK);
    RST <= 1'b0;
  end

endmodule

// ==== verilog/ls_subsystem_top.sv ====
// *********************************************************************
// Data-memory side of the core, writebacks double as a retire trace
// The issuer must hold off new operations while busy is high
// *********************************************************************

`timescale 1ns/1ps

module ls_subsystem_top (
  input  logic               CLK,
  input  logic               RST,
  input  logic               op_vld,
  input  ls_isa_pkg::ls_op_t op,
  output logic               busy,
  output ls_bus_pkg::rf_wr_t ptr_wb,
  output ls_bus_pkg::rf_wr_t load_wb,
  output ls_bus_pkg::rf_wr_t periph_wb
);

  import ls_isa_pkg::*;
  import ls_bus_pkg::*;

  reg_sel_t    ptr_sel;
  reg_sel_t    data_sel;
  logic [31:0] ptr_data;
  logic [31:0] store_data;
  dbus_req_t   ram_req;
  dbus_req_t   periph_req;
  bus_word_u   ram_rdata;
  logic        timer_start;
  logic        timer_done;

  // Address generation, store steering and load alignment
  load_store_unit load_store_unit_inst (
    .CLK        (CLK),
    .RST        (RST),
    .op_vld     (op_vld),
    .op         (op),
    .ptr_sel    (ptr_sel),
    .data_sel   (data_sel),
    .ptr_data   (ptr_data),
    .store_data (store_data),
    .ram_req    (ram_req),
    .periph_req (periph_req),
    .ram_rdata  (ram_rdata),
    .ptr_wb     (ptr_wb),
    .load_wb    (load_wb)
  );

  reg_file reg_file_inst (
    .CLK        (CLK),
    .RST        (RST),
    .ptr_sel    (ptr_sel),
    .data_sel   (data_sel),
    .ptr_data   (ptr_data),
    .store_data (store_data),
    .ptr_wb     (ptr_wb),
    .load_wb    (load_wb),
    .periph_wb  (periph_wb)
  );

  data_ram data_ram_inst (
    .CLK   (CLK),
    .RST   (RST),
    .req   (ram_req),
    .rdata (ram_rdata)
  );

  // Peripheral space is served through the bridge and its wait timer
  periph_bridge_ctrl periph_bridge_ctrl_inst (
    .CLK         (CLK),
    .RST         (RST),
    .req         (periph_req),
    .timer_start (timer_start),
    .timer_done  (timer_done),
    .busy        (busy),
    .periph_wb   (periph_wb)
  );

  wait_timer wait_timer_inst (
    .CLK   (CLK),
    .RST   (RST),
    .start (timer_start),
    .done  (timer_done)
  );

endmodule

// ==== verilog/wait_timer.sv ====
// *********************************************************************
// Fixed-delay down counter for peripheral accesses
// *********************************************************************

`timescale 1ns/1ps

module wait_timer (
  input  logic CLK,
  input  logic RST,
  input  logic start,
  output logic done
);

  import ls_bus_pkg::*;

  logic [WAIT_CNT_W-1:0] cnt;

  // Load on start, then count to zero and flag the last step
  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
    begin
      cnt  <= '0;
      done <= 1'b0;
    end
    else
    begin
      done <= 1'b0;
      if (start)
        cnt <= WAIT_CNT_W'(PERIPH_WAIT);
      else if (cnt != '0)
      begin
        cnt  <= cnt - 1'b1;
        done <= (cnt == WAIT_CNT_W'(1));
      end
    end
  end

endmodule

// ==== verilog/periph_bridge_ctrl.sv ====
// *********************************************************************
// Slow peripheral bridge in front of a 16-word register bank
// One access at a time; reads and swaps return the whole bank word
// *********************************************************************

`timescale 1ns/1ps

module periph_bridge_ctrl (
  input  logic                  CLK,
  input  logic                  RST,
  input  ls_bus_pkg::dbus_req_t req,
  output logic                  timer_start,
  input  logic                  timer_done,
  output logic                  busy,
  output ls_bus_pkg::rf_wr_t    periph_wb
);

  import ls_bus_pkg::*;

  typedef enum logic [1:0] {
    ST_IDLE,
    ST_WAIT,
    ST_COMPLETE
  } br_state_e;

  br_state_e            state_q;
  dbus_req_t            lat_q;
  bus_word_u            bank [PERIPH_WORDS];
  logic [PERIPH_AW-1:0] idx;

  // A new request is only accepted from idle, and it starts the timer
  assign timer_start = (state_q == ST_IDLE) && req.cs;
  assign busy        = (state_q != ST_IDLE);
  assign idx         = lat_q.addr[PERIPH_AW+1:2];

  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
      state_q <= ST_IDLE;
    else
    begin
      case (state_q)
        ST_IDLE:     if (req.cs) state_q <= ST_WAIT;
        ST_WAIT:     if (timer_done) state_q <= ST_COMPLETE;
        default:     state_q <= ST_IDLE;
      endcase
    end
  end

  // Hold the request for the whole access
  always_ff @(posedge CLK)
  begin
    if (timer_start)
      lat_q <= req;
  end

  // The masked write lands at the edge that leaves the complete state
  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
    begin
      for (int i = 0; i < PERIPH_WORDS; i++)
      begin
        bank[i] <= '0;
      end
    end
    else if ((state_q == ST_COMPLETE) && lat_q.wr)
    begin
      for (int j = 0; j < 4; j++)
      begin
        if (lat_q.mask[j])
          bank[idx].b[j] <= lat_q.data.b[j];
      end
    end
  end

  // Read before that write, so a swap returns the old word
  assign periph_wb = '{vld:  (state_q == ST_COMPLETE) && (!lat_q.wr || lat_q.swap),
                       sel:  lat_q.wb_sel,
                       data: bank[idx].w};

endmodule

// ==== verilog/data_ram.sv ====
// *********************************************************************
// No-wait data RAM, read data follows the request by one cycle
// Address bits above the index are ignored so the array wraps
// *********************************************************************

`timescale 1ns/1ps

module data_ram (
  input  logic                  CLK,
  input  logic                  RST,
  input  ls_bus_pkg::dbus_req_t req,
  output ls_bus_pkg::bus_word_u rdata
);

  import ls_bus_pkg::*;

  bus_word_u         mem [RAM_WORDS];
  logic [RAM_AW-1:0] idx;

  assign idx = req.addr[RAM_AW+1:2];

  // The old word is registered even on a write, so a swap returns it
  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
    begin
      for (int i = 0; i < RAM_WORDS; i++)
      begin
        mem[i] <= '0;
      end
      rdata <= '0;
    end
    else if (req.cs)
    begin
      rdata <= mem[idx];
      for (int j = 0; j < 4; j++)
      begin
        if (req.wr && req.mask[j])
          mem[idx].b[j] <= req.data.b[j];
      end
    end
  end

endmodule

// ==== verilog/reg_file.sv ====
// *********************************************************************
// Eight-entry register file with prioritized writes
// Same-register writes in one cycle keep only the highest-priority one
// *********************************************************************

`timescale 1ns/1ps

module reg_file (
  input  logic                 CLK,
  input  logic                 RST,
  input  ls_isa_pkg::reg_sel_t ptr_sel,
  input  ls_isa_pkg::reg_sel_t data_sel,
  output logic [31:0]          ptr_data,
  output logic [31:0]          store_data,
  input  ls_bus_pkg::rf_wr_t   ptr_wb,
  input  ls_bus_pkg::rf_wr_t   load_wb,
  input  ls_bus_pkg::rf_wr_t   periph_wb
);

  import ls_isa_pkg::*;

  logic [31:0] regs [REG_COUNT];

  // Both read ports are combinational
  assign ptr_data   = regs[ptr_sel];
  assign store_data = regs[data_sel];

  // Peripheral data wins over load data, which wins over a pointer update
  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
    begin
      for (int i = 0; i < REG_COUNT; i++)
      begin
        regs[i] <= 32'd0;
      end
    end
    else
    begin
      for (int i = 0; i < REG_COUNT; i++)
      begin
        if (periph_wb.vld && (periph_wb.sel == reg_sel_t'(i)))
          regs[i] <= periph_wb.data;
        else if (load_wb.vld && (load_wb.sel == reg_sel_t'(i)))
          regs[i] <= load_wb.data;
        else if (ptr_wb.vld && (ptr_wb.sel == reg_sel_t'(i)))
          regs[i] <= ptr_wb.data;
      end
    end
  end

endmodule

// ==== verilog/load_store_unit.sv ====
// *********************************************************************
// Address generation, store steering and no-wait load return
// Low address bits only pick byte lanes, misalignment is never faulted
// *********************************************************************

`timescale 1ns/1ps

module load_store_unit (
  input  logic                  CLK,
  input  logic                  RST,
  input  logic                  op_vld,
  input  ls_isa_pkg::ls_op_t    op,
  output ls_isa_pkg::reg_sel_t  ptr_sel,
  output ls_isa_pkg::reg_sel_t  data_sel,
  input  logic [31:0]           ptr_data,
  input  logic [31:0]           store_data,
  output ls_bus_pkg::dbus_req_t ram_req,
  output ls_bus_pkg::dbus_req_t periph_req,
  input  ls_bus_pkg::bus_word_u ram_rdata,
  output ls_bus_pkg::rf_wr_t    ptr_wb,
  output ls_bus_pkg::rf_wr_t    load_wb
);

  import ls_isa_pkg::*;
  import ls_bus_pkg::*;

  // One load in flight: size, byte lane and destination register
  typedef struct packed {
    logic     vld;
    ls_size_e size;
    logic [1:0] lane;
    reg_sel_t sel;
  } ld_stage_t;

  logic [31:0] imm_ext;
  logic [31:0] offset;
  logic [31:0] addr_next;
  logic [31:0] issue_addr;
  logic        post_inc;
  logic        is_swap;
  logic        periph_space;
  logic        load_pend;
  logic [3:0]  mask;
  bus_word_u   wdata;

  logic        ram_cs_q;
  logic        periph_cs_q;
  dbus_req_t   req_q;
  logic        ptr_vld_q;
  reg_sel_t    ptr_sel_q;
  logic [31:0] ptr_data_q;
  ld_stage_t   ld_s1;
  ld_stage_t   ld_s2;
  ld_stage_t   ld_s3;
  bus_word_u   rd_word;
  logic [31:0] load_data;

  // Register reads go straight from the operation fields
  assign ptr_sel  = op.ptr_sel;
  assign data_sel = op.data_sel;

  // The immediate is signed only when the pointer is updated
  assign imm_ext = op.upd ? {{27{op.imm[4]}}, op.imm} : {27'd0, op.imm};

  // Scale the offset to bytes by the access size
  always_comb
  begin
    case (op.size)
      SIZE_BYTE: offset = imm_ext;
      SIZE_HALF: offset = {imm_ext[30:0], 1'b0};
      default:   offset = {imm_ext[29:0], 2'b00};
    endcase
  end

  assign addr_next = ptr_data + offset;

  // A non-negative update offset accesses the old pointer (post-increment)
  // A negative one accesses the new pointer (pre-decrement)
  assign post_inc   = op.upd && !offset[31];
  assign issue_addr = post_inc ? ptr_data : addr_next;

  // Bit 31 splits the map between the RAM and the slow peripheral space
  assign periph_space = issue_addr[31];
  assign is_swap      = op.wr && (op.size == SIZE_SWAP);

  // Plain loads and swaps in data space return a word on load_wb
  assign load_pend = !periph_space && (!op.wr || is_swap);

  // Replicate store data on every lane and enable only the addressed ones
  always_comb
  begin
    case (op.size)
      SIZE_BYTE:
      begin
        wdata.b = {4{store_data[7:0]}};
        mask    = 4'b0001 << issue_addr[1:0];
      end
      SIZE_HALF:
      begin
        wdata.h = {2{store_data[15:0]}};
        mask    = issue_addr[1] ? 4'b1100 : 4'b0011;
      end
      default:
      begin
        wdata.w = store_data;
        mask    = 4'b1111;
      end
    endcase
  end

  // Strobes of both requests, the pointer write and the load pipeline
  always_ff @(posedge CLK or posedge RST)
  begin
    if (RST)
    begin
      ram_cs_q    <= 1'b0;
      periph_cs_q <= 1'b0;
      ptr_vld_q   <= 1'b0;
      ld_s1       <= '0;
      ld_s2       <= '0;
      ld_s3       <= '0;
    end
    else
    begin
      ram_cs_q    <= op_vld && !periph_space;
      periph_cs_q <= op_vld && periph_space;
      ptr_vld_q   <= op_vld && op.upd;
      ld_s1.vld   <= op_vld && load_pend;
      ld_s1.size  <= op.size;
      ld_s1.lane  <= issue_addr[1:0];
      ld_s1.sel   <= op.data_sel;
      ld_s2       <= ld_s1;
      ld_s3       <= ld_s2;
    end
  end

  // Request and pointer payload only change with a new operation
  always_ff @(posedge CLK)
  begin
    if (op_vld)
    begin
      req_q.addr   <= {issue_addr[31:2], 2'b00};
      req_q.cs     <= 1'b0;
      req_q.wr     <= op.wr;
      req_q.swap   <= is_swap;
      req_q.mask   <= mask;
      req_q.data   <= wdata;
      req_q.wb_sel <= op.data_sel;
      ptr_sel_q    <= op.ptr_sel;
      ptr_data_q   <= addr_next;
    end
  end

  // Both buses see the same payload, only the chip select differs
  always_comb
  begin
    ram_req       = req_q;
    ram_req.cs    = ram_cs_q;
    periph_req    = req_q;
    periph_req.cs = periph_cs_q;
  end

  assign ptr_wb = '{vld: ptr_vld_q, sel: ptr_sel_q, data: ptr_data_q};

  // RAM data is valid one cycle after the request, hold it for alignment
  always_ff @(posedge CLK)
  begin
    if (ld_s2.vld)
    begin
      rd_word <= ram_rdata;
    end
  end

  // Zero-extend the addressed lane, words and swaps pass unchanged
  always_comb
  begin
    case (ld_s3.size)
      SIZE_BYTE: load_data = {24'd0, rd_word.b[ld_s3.lane]};
      SIZE_HALF: load_data = {16'd0, rd_word.h[ld_s3.lane[1]]};
      default:   load_data = rd_word.w;
    endcase
  end

  assign load_wb = '{vld: ld_s3.vld, sel: ld_s3.sel, data: load_data};

endmodule

// ==== verilog/ls_bus_pkg.sv ====
// *********************************************************************
// Data bus, writeback and memory sizing shared by the load/store path
// RAM and peripheral indices wrap; there is no range or alignment check
// *********************************************************************

package ls_bus_pkg;

  // Local data RAM, indexed by address bits 7:2
  localparam int RAM_WORDS = 64;
  localparam int RAM_AW = $clog2(RAM_WORDS);

  // Peripheral register bank, indexed by address bits 5:2
  localparam int PERIPH_WORDS = 16;
  localparam int PERIPH_AW = $clog2(PERIPH_WORDS);

  // Cycles the bridge waits before completing a peripheral access
  localparam int PERIPH_WAIT = 4;
  localparam int WAIT_CNT_W = $clog2(PERIPH_WAIT + 1);

  // One bus word, seen as a whole, as two halves or as four bytes
  typedef union packed {
    logic [31:0] w;
    logic [1:0][15:0] h;
    logic [3:0][7:0] b;
  } bus_word_u;

  // Request to the data RAM or the peripheral bridge
  typedef struct packed {
    // Word-aligned address, the low two bits are always zero
    logic [31:0] addr;
    logic cs;
    logic wr;
    logic swap;
    // One bit per byte lane, lane 0 is bits 7:0
    logic [3:0] mask;
    bus_word_u data;
    // Destination register for returned data
    ls_isa_pkg::reg_sel_t wb_sel;
  } dbus_req_t;

  // One register file write
  typedef struct packed {
    logic vld;
    ls_isa_pkg::reg_sel_t sel;
    logic [31:0] data;
  } rf_wr_t;

endpackage

// ==== verilog/ls_isa_pkg.sv ====
// *********************************************************************
// Load/store operation encoding for an eight-register 32-bit core
// Field order is fixed by the 15-bit operation word on the issue strobe
// *********************************************************************

package ls_isa_pkg;

  // The core has eight general registers
  localparam int REG_COUNT = 8;

  // Index of one of the eight registers
  typedef logic [2:0] reg_sel_t;

  // Access size codes as carried in the operation word
  // Code 3 is a full word access that becomes a swap when wr is also set
  typedef enum logic [1:0] {
    SIZE_BYTE = 2'd0,
    SIZE_HALF = 2'd1,
    SIZE_WORD = 2'd2,
    SIZE_SWAP = 2'd3
  } ls_size_e;

  // Operation word, most significant field first
  typedef struct packed {
    // Store when set, load when clear
    logic     wr;
    // Write the updated pointer back to ptr_sel
    logic     upd;
    ls_size_e size;
    // Offset in units of the access size
    // Sign-extended with upd, zero-extended without it
    logic [4:0] imm;
    // Register that supplies the base address
    reg_sel_t ptr_sel;
    // Store source, and load destination
    reg_sel_t data_sel;
  } ls_op_t;

endpackage
